// File: source/dep_macros.svh
`ifndef DEP_MACROS_SVH
`define DEP_MACROS_SVH

// general register file, byte lanes 7:0, 15:8 and 31:16.
`define DEP_NUM_GPR     8
`define DEP_GPR_LANES   3
`define DEP_GPR_SB_W    (`DEP_NUM_GPR * `DEP_GPR_LANES)

// register number width, shared by all files.
`define DEP_REG_ID_W    3

// segment and mmx files, one scoreboard bit per register.
`define DEP_NUM_SEG     8
`define DEP_NUM_MM      8

// in-flight stages ag2, me, me2, ex.
`define DEP_PIPE_DEPTH  4

// instruction tag width.
`define DEP_TAG_W       8

`endif

// File: source/dep_operand_pkg.sv
`include "dep_macros.svh"

package dep_operand_pkg;

   typedef logic [`DEP_REG_ID_W-1:0] reg_id_t;

   typedef enum logic [1:0] {
      SZ_BYTE  = 2'd0,  // al..bl, ah..bh.
      SZ_WORD  = 2'd1,
      SZ_DWORD = 2'd2
   } opnd_size_e;

   // opcode class of the destination.
   typedef enum logic [1:0] {
      DST_NONE = 2'd0,
      DST_GPR  = 2'd1,
      DST_SEG  = 2'd2,
      DST_MM   = 2'd3
   } dst_kind_e;

   typedef struct packed {
      logic       needed;
      reg_id_t    id;
      opnd_size_e size;
   } gpr_src_t;

   typedef struct packed {
      gpr_src_t              sr1;
      gpr_src_t              sr2;
      gpr_src_t              sr3;
      gpr_src_t              sib_i;
      logic                  seg1_needed;
      reg_id_t               seg1_id;
      logic                  seg2_needed;
      reg_id_t               seg2_id;
      logic                  mm1_needed;   // mmx ids come from sr1.id.
      logic                  mm2_needed;   // and sr2.id.
      dst_kind_e             dst_kind;
      reg_id_t               dst_id;
      opnd_size_e            dst_size;
      logic [`DEP_TAG_W-1:0] tag;
   } dep_instr_t;

   function automatic logic [`DEP_GPR_SB_W-1:0] gpr_lane_mask(input reg_id_t id,
                                                             input opnd_size_e size);
      logic [`DEP_GPR_SB_W-1:0] mask;
      int unsigned              base;
      mask = '0;
      base = `DEP_GPR_LANES * int'(id);
      case (size)
         SZ_BYTE: begin
            // ids 4..7 are the high bytes of registers 0..3.
            if (id[2]) mask[`DEP_GPR_LANES * int'(id[1:0]) + 1] = 1'b1;
            else mask[base] = 1'b1;
         end
         SZ_WORD:  mask[base +: 2] = 2'b11;
         SZ_DWORD: mask[base +: `DEP_GPR_LANES] = '1;
         default:  mask = '0;
      endcase
      return mask;
   endfunction

endpackage

// File: source/dep_pipe_pkg.sv
`include "dep_macros.svh"

package dep_pipe_pkg;

   // bit 3*id+lane for gprs, bit id for seg and mm.
   typedef struct packed {
      logic [`DEP_GPR_SB_W-1:0] gpr;
      logic [`DEP_NUM_SEG-1:0]  seg;
      logic [`DEP_NUM_MM-1:0]   mm;
   } scoreboard_t;

   typedef enum logic [1:0] {
      ST_AG2 = 2'd0,
      ST_ME  = 2'd1,
      ST_ME2 = 2'd2,
      ST_EX  = 2'd3
   } pipe_stage_e;

   typedef struct packed {
      logic                        valid;
      scoreboard_t                 sb;     // registers this entry will write.
      dep_operand_pkg::dep_instr_t instr;
   } stage_entry_t;

endpackage

// File: source/gpr_hazard_check.sv
`timescale 1ns/1ns
`include "dep_macros.svh"

module gpr_hazard_check (
   input  logic                          stage_v,
   input  dep_operand_pkg::gpr_src_t     sr1,
   input  dep_operand_pkg::gpr_src_t     sr2,
   input  dep_operand_pkg::gpr_src_t     sr3,
   input  dep_operand_pkg::gpr_src_t     sib_i,
   input  logic [`DEP_GPR_SB_W-1:0]      gpr_busy,
   output logic                          stall
);

   import dep_operand_pkg::*;

   localparam int NUM_SRC = 4;

   gpr_src_t          srcs [NUM_SRC];
   logic [NUM_SRC-1:0] hit;

   assign srcs[0] = sr1;
   assign srcs[1] = sr2;
   assign srcs[2] = sr3;
   assign srcs[3] = sib_i;   // sib index register.

   // a source conflicts only if one of its own lanes is pending,
   // so ah reads past an al writer but not past an ax writer.
   always_comb begin
      for (int i = 0; i < NUM_SRC; i++) begin
         hit[i] = srcs[i].needed &&
                  (|(gpr_lane_mask(srcs[i].id, srcs[i].size) & gpr_busy));
      end
   end

   assign stall = stage_v && (|hit);

endmodule

// File: source/seg_mm_hazard_check.sv
`timescale 1ns/1ns
`include "dep_macros.svh"

module seg_mm_hazard_check (
   input  logic                         stage_v,
   input  logic                         seg1_needed,
   input  logic                         seg2_needed,
   input  dep_operand_pkg::reg_id_t     seg1_id,
   input  dep_operand_pkg::reg_id_t     seg2_id,
   input  logic                         mm1_needed,
   input  logic                         mm2_needed,
   input  dep_operand_pkg::reg_id_t     sr1_id,
   input  dep_operand_pkg::reg_id_t     sr2_id,
   input  logic [`DEP_NUM_SEG-1:0]      seg_busy,
   input  logic [`DEP_NUM_MM-1:0]       mm_busy,
   output logic                         stall
);

   import dep_operand_pkg::*;

   function automatic logic [7:0] id_onehot(input reg_id_t id);
      return 8'b1 << id;
   endfunction

   logic seg1_hit, seg2_hit;
   logic mm1_hit, mm2_hit;

   assign seg1_hit = seg1_needed && (|(id_onehot(seg1_id) & seg_busy));
   assign seg2_hit = seg2_needed && (|(id_onehot(seg2_id) & seg_busy));
   assign mm1_hit  = mm1_needed && (|(id_onehot(sr1_id) & mm_busy));   // gpr writers ignored.
   assign mm2_hit  = mm2_needed && (|(id_onehot(sr2_id) & mm_busy));

   assign stall = stage_v && (seg1_hit || seg2_hit || mm1_hit || mm2_hit);

endmodule

// File: source/scoreboard_pipe.sv
`timescale 1ns/1ns
`include "dep_macros.svh"

module scoreboard_pipe #(
   parameter int DEPTH = `DEP_PIPE_DEPTH
) (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          issue,
   input  dep_operand_pkg::dep_instr_t   issue_instr,
   output dep_pipe_pkg::scoreboard_t     busy,
   output logic                          advance,
   output logic                          out_valid,
   input  logic                          out_ready,
   output dep_operand_pkg::dep_instr_t   out_instr
);

   import dep_operand_pkg::*;
   import dep_pipe_pkg::*;

   stage_entry_t stage [DEPTH];   // index 0 is ag2, DEPTH-1 is ex.
   stage_entry_t new_entry;
   scoreboard_t  new_sb;

   // write scoreboard of the instruction entering ag2.
   always_comb begin
      new_sb = '0;
      case (issue_instr.dst_kind)
         DST_GPR: new_sb.gpr = gpr_lane_mask(issue_instr.dst_id, issue_instr.dst_size);
         DST_SEG: new_sb.seg[issue_instr.dst_id] = 1'b1;
         DST_MM:  new_sb.mm[issue_instr.dst_id] = 1'b1;
         default: new_sb = '0;   // no destination.
      endcase
   end

   always_comb begin
      new_entry.valid = 1'b1;
      new_entry.sb    = new_sb;
      new_entry.instr = issue_instr;
   end

   // ex drains or is empty, so every stage may move.
   assign advance = !stage[DEPTH-1].valid || out_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         stage <= '{default: '0};
      end else if (advance) begin
         stage[int'(ST_AG2)] <= issue ? new_entry : '0;   // bubble when stalled.
         for (int i = 1; i < DEPTH; i++) begin
            stage[i] <= stage[i-1];
         end
      end
   end

   // pending writes of every valid stage, ex included until it retires.
   always_comb begin
      busy = '0;
      for (int i = 0; i < DEPTH; i++) begin
         if (stage[i].valid) begin
            busy = busy | stage[i].sb;
         end
      end
   end

   assign out_valid = stage[DEPTH-1].valid;
   assign out_instr = stage[DEPTH-1].instr;

endmodule

// File: source/dep_issue_ctrl.sv
`timescale 1ns/1ns

module dep_issue_ctrl (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        in_valid,
   input  logic        gpr_stall,
   input  logic        segmm_stall,
   input  logic        advance,
   output logic        in_ready,
   output logic        issue,
   output logic [15:0] stall_cycles
);

   logic dep_stall;

   // checker stalls already carry in_valid.
   assign dep_stall = gpr_stall || segmm_stall;

   assign in_ready = advance && !dep_stall;
   assign issue    = in_valid && in_ready;

   // cycles an offered instruction was held back.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         stall_cycles <= '0;
      end else if (in_valid && !in_ready) begin
         stall_cycles <= stall_cycles + 16'd1;
      end
   end

endmodule

// File: source/dep_check_top.sv
`timescale 1ns/1ns

module dep_check_top (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          in_valid,
   output logic                          in_ready,
   input  dep_operand_pkg::dep_instr_t   in_instr,
   output logic                          out_valid,
   input  logic                          out_ready,
   output dep_operand_pkg::dep_instr_t   out_instr,
   output logic [15:0]                   stall_cycles
);

   import dep_pipe_pkg::*;

   scoreboard_t busy;
   logic        advance;
   logic        issue;
   logic        gpr_stall;
   logic        segmm_stall;

   dep_issue_ctrl u_issue_ctrl (
      .clk          (clk),
      .arst_n       (arst_n),
      .in_valid     (in_valid),
      .gpr_stall    (gpr_stall),
      .segmm_stall  (segmm_stall),
      .advance      (advance),
      .in_ready     (in_ready),
      .issue        (issue),
      .stall_cycles (stall_cycles)
   );

   gpr_hazard_check u_gpr_check (
      .stage_v  (in_valid),
      .sr1      (in_instr.sr1),
      .sr2      (in_instr.sr2),
      .sr3      (in_instr.sr3),
      .sib_i    (in_instr.sib_i),
      .gpr_busy (busy.gpr),
      .stall    (gpr_stall)
   );

   seg_mm_hazard_check u_seg_mm_check (
      .stage_v     (in_valid),
      .seg1_needed (in_instr.seg1_needed),
      .seg2_needed (in_instr.seg2_needed),
      .seg1_id     (in_instr.seg1_id),
      .seg2_id     (in_instr.seg2_id),
      .mm1_needed  (in_instr.mm1_needed),
      .mm2_needed  (in_instr.mm2_needed),
      .sr1_id      (in_instr.sr1.id),   // mmx sources share the sr ids.
      .sr2_id      (in_instr.sr2.id),
      .seg_busy    (busy.seg),
      .mm_busy     (busy.mm),
      .stall       (segmm_stall)
   );

   scoreboard_pipe u_pipe (
      .clk         (clk),
      .arst_n      (arst_n),
      .issue       (issue),
      .issue_instr (in_instr),
      .busy        (busy),
      .advance     (advance),
      .out_valid   (out_valid),
      .out_ready   (out_ready),
      .out_instr   (out_instr)
   );

endmodule

// File: bench/dep_check_tb.sv
`timescale 1ns/1ns
`include "dep_macros.svh"

module dep_check_tb;

   import dep_operand_pkg::*;
   import dep_pipe_pkg::*;

   logic        clk;
   logic        arst_n;
   logic        in_valid;
   logic        in_ready;
   dep_instr_t  in_instr;
   logic        out_valid;
   logic        out_ready;
   dep_instr_t  out_instr;
   logic [15:0] stall_cycles;

   dep_instr_t  shadow [$];   // accepted, not yet retired.
   logic [15:0] lfsr;
   logic [7:0]  next_tag = 8'd1;
   logic [15:0] stall_count = '0;
   int          error_count = 0;
   int          timeout_count = 0;
   int          retired = 0;
   logic        timed_out = 1'b0;
   logic        exp_ready;
   logic        held_valid = 1'b0;
   dep_instr_t  held_instr;

   dep_check_top DUT (
      .clk          (clk),
      .arst_n       (arst_n),
      .in_valid     (in_valid),
      .in_ready     (in_ready),
      .in_instr     (in_instr),
      .out_valid    (out_valid),
      .out_ready    (out_ready),
      .out_instr    (out_instr),
      .stall_cycles (stall_cycles)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;

   // galois lfsr, taps 16 14 13 11, one step per bit.
   function automatic logic [7:0] rand_bits(input int n);
      logic [7:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[6:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      end
      return v;
   endfunction

   function automatic logic [`DEP_GPR_SB_W-1:0] lanes_of(input reg_id_t id,
                                                        input opnd_size_e size);
      int r;
      r = int'(id);
      if (size == SZ_BYTE) begin
         if (r >= 4) return 24'h2 << (3 * (r - 4));   // ah, ch, dh, bh.
         return 24'h1 << (3 * r);
      end
      if (size == SZ_WORD) return 24'h3 << (3 * r);
      return 24'h7 << (3 * r);
   endfunction

   function automatic scoreboard_t writes_of(input dep_instr_t w);
      scoreboard_t s;
      s = '0;
      if (w.dst_kind == DST_GPR) s.gpr = lanes_of(w.dst_id, w.dst_size);
      if (w.dst_kind == DST_SEG) s.seg = 8'h1 << w.dst_id;
      if (w.dst_kind == DST_MM) s.mm = 8'h1 << w.dst_id;
      return s;
   endfunction

   function automatic logic src_hits(input gpr_src_t s, input logic [`DEP_GPR_SB_W-1:0] w);
      return s.needed && (|(lanes_of(s.id, s.size) & w));
   endfunction

   function automatic logic ref_conflict(input dep_instr_t r);
      scoreboard_t w;
      logic        hit;
      hit = 1'b0;
      foreach (shadow[i]) begin
         w = writes_of(shadow[i]);
         hit |= src_hits(r.sr1, w.gpr) || src_hits(r.sr2, w.gpr);
         hit |= src_hits(r.sr3, w.gpr) || src_hits(r.sib_i, w.gpr);
         hit |= (r.seg1_needed && w.seg[r.seg1_id]) || (r.seg2_needed && w.seg[r.seg2_id]);
         hit |= (r.mm1_needed && w.mm[r.sr1.id]) || (r.mm2_needed && w.mm[r.sr2.id]);
      end
      return hit;
   endfunction

   function automatic dep_instr_t blank_instr();
      dep_instr_t x;
      x = '0;
      x.tag = next_tag;
      next_tag = next_tag + 8'd1;
      return x;
   endfunction

   function automatic gpr_src_t src(input reg_id_t id, input opnd_size_e size);
      gpr_src_t s;
      s.needed = 1'b1;
      s.id = id;
      s.size = size;
      return s;
   endfunction

   // eax, ecx and their high-byte aliases, so hazards come often.
   function automatic reg_id_t pick_id();
      logic [7:0] a;
      logic [7:0] b;
      a = rand_bits(1);
      b = rand_bits(1);
      return {a[0], 1'b0, b[0]};
   endfunction

   function automatic opnd_size_e pick_size();
      logic [7:0] v;
      v = rand_bits(2);
      if (v == 8'd0) return SZ_BYTE;
      if (v == 8'd1) return SZ_WORD;
      return SZ_DWORD;
   endfunction

   function automatic gpr_src_t random_src(input int need_bits);
      gpr_src_t s;
      s.id = pick_id();
      s.size = pick_size();
      s.needed = (rand_bits(need_bits) == 8'd0);
      return s;
   endfunction

   function automatic dep_instr_t random_instr();
      dep_instr_t x;
      logic [7:0] v;
      x = blank_instr();
      x.sr1 = random_src(1);
      x.sr2 = random_src(1);
      x.sr3 = random_src(2);
      x.sib_i = random_src(2);
      x.seg1_needed = (rand_bits(2) == 8'd0);
      v = rand_bits(1);
      x.seg1_id = {2'b00, v[0]};
      x.seg2_needed = (rand_bits(2) == 8'd0);
      v = rand_bits(1);
      x.seg2_id = {2'b00, v[0]};
      x.mm1_needed = (rand_bits(2) == 8'd0);
      x.mm2_needed = (rand_bits(2) == 8'd0);
      v = rand_bits(2);
      x.dst_kind = dst_kind_e'(v[1:0]);
      x.dst_id = pick_id();
      x.dst_size = pick_size();
      return x;
   endfunction

   task automatic note_timeout(input string what);
      $display("timeout: %s did not complete in time", what);
      timeout_count++;
      timed_out = 1'b1;
   endtask

   // offer x from a falling edge until it is taken.
   task automatic send(input dep_instr_t x, input string what);
      logic got;
      int   n;
      if (timed_out) return;
      got = 1'b0;
      n = 0;
      in_valid = 1'b1;
      in_instr = x;
      while (!got && n < 40) begin
         @(posedge clk);
         got = in_ready;
         @(negedge clk);
         n++;
      end
      if (!got) note_timeout(what);
   endtask

   task automatic drain(input string what);
      int n;
      if (timed_out) return;
      n = 0;
      while ((shadow.size() != 0 || out_valid) && n < 40) begin
         @(negedge clk);
         n++;
      end
      if (shadow.size() != 0 || out_valid) note_timeout({what, " drain"});
   endtask

   task automatic settle(input string what);
      out_ready = 1'b1;
      if (in_valid) send(in_instr, what);
      in_valid = 1'b0;
      drain(what);
   endtask

   task automatic pair_case(input dep_instr_t writer, input dep_instr_t reader,
                            input logic expect_wait, input string name);
      logic first_ready;
      if (timed_out) return;
      drain(name);
      send(writer, name);
      in_instr = reader;   // reader offered right behind its writer.
      @(posedge clk);
      first_ready = in_ready;
      @(negedge clk);
      assert (first_ready === !expect_wait) else begin
         $display("[ERROR] in_ready: expected 0x%0h, actual 0x%0h in case %s",
                  !expect_wait, first_ready, name);
         error_count++;
      end
      if (!first_ready) send(reader, name);
      in_valid = 1'b0;
   endtask

   task automatic random_traffic(input int cycles, input logic block_out);
      logic       took;
      logic [7:0] v;
      for (int c = 0; c < cycles; c++) begin
         @(posedge clk);
         took = in_valid && in_ready;
         @(negedge clk);
         if (!in_valid || took) begin
            v = rand_bits(2);
            in_valid = (v != 8'd0);
            in_instr = random_instr();
         end
         v = rand_bits(2);
         out_ready = block_out ? 1'b0 : (v != 8'd0);   // low about a quarter.
      end
   endtask

   // transfers are sampled at the rising edge, before the stages update.
   always @(posedge clk) begin
      if (!arst_n) begin
         assert (out_valid === 1'b0) else begin
            $display("[ERROR] out_valid: expected 0x0, actual 0x%0h in reset", out_valid);
            error_count++;
         end
         assert (!in_valid || in_ready === 1'b1) else begin
            $display("[ERROR] in_ready: expected 0x1, actual 0x%0h in reset", in_ready);
            error_count++;
         end
      end else begin
         if (in_valid) begin
            exp_ready = !ref_conflict(in_instr) && !(out_valid && !out_ready);
            assert (in_ready === exp_ready) else begin
               $display("[ERROR] in_ready: expected 0x%0h, actual 0x%0h, tag 0x%0h",
                        exp_ready, in_ready, in_instr.tag);
               error_count++;
            end
         end
         assert (stall_cycles === stall_count) else begin
            $display("[ERROR] stall_cycles: expected 0x%0h, actual 0x%0h",
                     stall_count, stall_cycles);
            error_count++;
         end
         if (held_valid) begin
            assert (out_valid && out_instr === held_instr) else begin
               $display("[ERROR] out_instr: expected 0x%0h, actual 0x%0h under back-pressure",
                        held_instr, out_instr);
               error_count++;
            end
         end
         if (out_valid && out_ready) begin
            assert (shadow.size() != 0) else begin
               $display("retire transfer with no instruction outstanding");
               error_count++;
            end
            if (shadow.size() != 0) begin
               assert (out_instr === shadow[0]) else begin
                  $display("[ERROR] out_instr: expected 0x%0h, actual 0x%0h",
                           shadow[0], out_instr);
                  error_count++;
               end
               void'(shadow.pop_front());
               retired++;
            end
         end
         if (in_valid && in_ready) shadow.push_back(in_instr);
         if (in_valid && !in_ready) stall_count = stall_count + 16'd1;
         held_valid = out_valid && !out_ready;
         held_instr = out_instr;
      end
   end

   initial begin
      dep_instr_t w;
      dep_instr_t r;
      int         n;
      lfsr = 16'd60092;
      arst_n = 1'b0;
      in_valid = 1'b1;   // offered through reset, taken right after.
      in_instr = '0;
      out_ready = 1'b1;
      repeat (16) @(negedge clk);
      arst_n = 1'b1;
      send(in_instr, "first instruction after reset");
      in_valid = 1'b0;
      drain("first instruction");

      send(blank_instr(), "latency probe");
      in_valid = 1'b0;
      n = 0;
      while (!timed_out && !out_valid && n < 12) begin
         @(negedge clk);
         n++;
      end
      if (!timed_out && !out_valid) note_timeout("retire of latency probe");
      else if (!timed_out) begin
         assert (n == 3) else begin
            $display("[ERROR] out_valid: expected rise after 0x3 cycles, actual 0x%0h", n);
            error_count++;
         end
      end

      w = blank_instr();
      w.dst_kind = DST_GPR;
      w.dst_id = 3'd0;
      w.dst_size = SZ_BYTE;
      r = blank_instr();
      r.sr1 = src(3'd4, SZ_BYTE);
      pair_case(w, r, 1'b0, "ah behind al writer");
      w = blank_instr();
      w.dst_kind = DST_GPR;
      w.dst_id = 3'd4;
      w.dst_size = SZ_BYTE;
      r = blank_instr();
      r.sr2 = src(3'd0, SZ_WORD);
      pair_case(w, r, 1'b1, "ax behind ah writer");
      w = blank_instr();
      w.dst_kind = DST_GPR;
      w.dst_id = 3'd0;
      w.dst_size = SZ_DWORD;
      r = blank_instr();
      r.sib_i = src(3'd0, SZ_DWORD);
      pair_case(w, r, 1'b1, "sib index behind eax writer");
      w = blank_instr();
      w.dst_kind = DST_SEG;
      w.dst_id = 3'd3;
      r = blank_instr();
      r.seg1_needed = 1'b1;
      r.seg1_id = 3'd3;
      pair_case(w, r, 1'b1, "segment source behind segment writer");
      w = blank_instr();
      w.dst_kind = DST_MM;
      w.dst_id = 3'd2;
      r = blank_instr();
      r.mm1_needed = 1'b1;
      r.sr1.id = 3'd2;   // mmx id only, gpr operand not needed.
      pair_case(w, r, 1'b1, "mmx source behind mmx writer");
      w.dst_kind = DST_GPR;
      w.dst_size = SZ_DWORD;
      w.tag = next_tag;
      r.tag = next_tag + 8'd1;
      next_tag = next_tag + 8'd2;
      pair_case(w, r, 1'b0, "mmx source behind gpr writer");

      if (!timed_out) random_traffic(600, 1'b0);
      settle("random traffic");
      if (!timed_out) random_traffic(16, 1'b1);
      settle("back-pressure release");

      $display("errors: %0d, timeouts: %0d, retired: %0d, stall cycles: %0d",
               error_count, timeout_count, retired, stall_cycles);
      if (error_count == 0 && timeout_count == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: list.f
+incdir+source
source/dep_operand_pkg.sv
source/dep_pipe_pkg.sv
source/gpr_hazard_check.sv
source/seg_mm_hazard_check.sv
source/scoreboard_pipe.sv
source/dep_issue_ctrl.sv
source/dep_check_top.sv
bench/dep_check_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, then search the log for the fail message.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --assert -Wno-fatal --top-module dep_check_tb -f list.f \
   -o dep_check_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/dep_check_sim > sim.log 2>&1 || echo "simulator returned an error" >> sim.log
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1
grep -q "PASS: all tests" sim.log || { echo "no result line in sim.log"; exit 1; }
exit 0
